// ==== hdl/mera_pkg.sv ====
`default_nettype none

package mera_pkg;

	// ----------------------------------------------------------------------
	// machine word and bus address
	// ----------------------------------------------------------------------

	// bit 0 is the msb, as on the original machine
	typedef logic [0:15] word_t;

	// full 16-bit address space, same width as a word
	typedef logic [0:15] addr_t;

	// ----------------------------------------------------------------------
	// panel command set
	// ----------------------------------------------------------------------

	// first byte of every serial frame
	typedef enum logic [7:0] {
		// load panel address register from frame data
		OP_LOAD  = 8'h01,
		// write frame data at address register
		OP_STORE = 8'h02,
		// read word at address register
		OP_FETCH = 8'h03,
		// request a system clear
		OP_CLEAR = 8'h04
	} op_t;

	// status byte bases, opcode gets or-ed into the low bits
	localparam logic [7:0] ST_OK    = 8'h80;
	localparam logic [7:0] ST_NOMEM = 8'h40;
	// answer to an unknown opcode
	localparam logic [7:0] ST_NAK   = 8'h15;

endpackage

`default_nettype wire

// ==== hdl/uart_link.sv ====
`default_nettype none

module uart_link #(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       rxd,
	output logic       txd,
	output logic       rx_valid,
	output logic [7:0] rx_byte,
	input  logic       tx_start,
	input  logic [7:0] tx_byte,
	output logic       tx_busy
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT);
	// last clock of a bit period
	localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);
	// middle of the start bit
	localparam logic [CNT_W-1:0] BIT_HALF = CNT_W'(CLKS_PER_BIT / 2 - 1);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

	rx_state_t        rx_state;
	logic             rx_meta;
	logic             rx_s;
	logic [CNT_W-1:0] rx_cnt;
	logic [2:0]       rx_bit;
	logic [7:0]       rx_shift;

	logic             tx_go;
	logic [CNT_W-1:0] tx_cnt;
	logic [3:0]       tx_bit;
	logic [9:0]       tx_shift;

	// ----------------------------------------------------------------------
	// receiver
	// ----------------------------------------------------------------------

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			// line idles high
			rx_meta  <= 1'b1;
			rx_s     <= 1'b1;
			rx_state <= RX_IDLE;
			rx_cnt   <= '0;
			rx_bit   <= '0;
			rx_valid <= 1'b0;
		end else begin
			// two-flop sync of the async line
			rx_meta  <= rxd;
			rx_s     <= rx_meta;
			rx_valid <= 1'b0;
			case (rx_state)
				RX_IDLE: begin
					rx_cnt <= '0;
					// falling edge = start bit
					if (!rx_s)
						rx_state <= RX_START;
				end
				RX_START: begin
					if (rx_cnt == BIT_HALF) begin
						rx_cnt <= '0;
						rx_bit <= '0;
						// high again at mid-bit means a glitch
						rx_state <= rx_s ? RX_IDLE : RX_DATA;
					end else
						rx_cnt <= rx_cnt + 1'b1;
				end
				RX_DATA: begin
					if (rx_cnt == BIT_LAST) begin
						rx_cnt <= '0;
						if (rx_bit == 3'd7)
							rx_state <= RX_STOP;
						else
							rx_bit <= rx_bit + 1'b1;
					end else
						rx_cnt <= rx_cnt + 1'b1;
				end
				default: begin
					if (rx_cnt == BIT_LAST) begin
						rx_state <= RX_IDLE;
						// bad stop bit, byte dropped
						rx_valid <= rx_s;
					end else
						rx_cnt <= rx_cnt + 1'b1;
				end
			endcase
		end
	end

	// data bits arrive lsb first
	always_ff @(posedge clk) begin
		if (rx_state == RX_DATA && rx_cnt == BIT_LAST)
			rx_shift <= {rx_s, rx_shift[7:1]};
	end

	assign rx_byte = rx_shift;

	// ----------------------------------------------------------------------
	// transmitter
	// ----------------------------------------------------------------------

	assign tx_go = tx_start && !tx_busy;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			tx_busy <= 1'b0;
			tx_cnt  <= '0;
			tx_bit  <= '0;
		end else if (tx_go) begin
			tx_busy <= 1'b1;
			tx_cnt  <= '0;
			tx_bit  <= '0;
		end else if (tx_busy) begin
			if (tx_cnt == BIT_LAST) begin
				tx_cnt <= '0;
				// start + 8 data + stop
				if (tx_bit == 4'd9)
					tx_busy <= 1'b0;
				else
					tx_bit <= tx_bit + 1'b1;
			end else
				tx_cnt <= tx_cnt + 1'b1;
		end
	end

	// stop, data, start, shifted out from bit 0
	always_ff @(posedge clk) begin
		if (tx_go)
			tx_shift <= {1'b1, tx_byte, 1'b0};
		else if (tx_busy && tx_cnt == BIT_LAST)
			tx_shift <= {1'b1, tx_shift[9:1]};
	end

	assign txd = tx_busy ? tx_shift[0] : 1'b1;

	// panel side must honour back-pressure
	a_tx_start_idle: assert property (@(posedge clk) disable iff (!arst_n)
		tx_start |-> !tx_busy)
		else $error("tx_start while transmitter busy");

endmodule

`default_nettype wire

// ==== hdl/power_seq.sv ====
`default_nettype none

module power_seq #(
	parameter int PON_CYCLES   = 40,
	parameter int CLEAR_CYCLES = 4
) (
	input  logic clk,
	input  logic arst_n,
	input  logic clr_req,
	output logic pwr_ok,
	output logic clm_
);

	localparam int PW = $clog2(PON_CYCLES + 1);
	localparam int CW = $clog2(CLEAR_CYCLES + 1);
	// last count of the power-on hold
	localparam logic [PW-1:0] PON_LAST = PW'(PON_CYCLES - 1);
	// clear pulse length
	localparam logic [CW-1:0] CLR_LEN  = CW'(CLEAR_CYCLES);

	logic [PW-1:0] pon_cnt;
	logic [CW-1:0] clr_cnt;
	logic          pon_end;
	logic          clear_src;

	// ----------------------------------------------------------------------
	// power-on hold
	// ----------------------------------------------------------------------

	// one cycle before pwr_ok comes up
	assign pon_end = !pwr_ok && (pon_cnt == PON_LAST);

	// ----------------------------------------------------------------------
	// clear merging
	// ----------------------------------------------------------------------

	// power-on clear or panel clear
	assign clear_src = pon_end || clr_req;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pon_cnt <= '0;
			pwr_ok  <= 1'b0;
			clr_cnt <= '0;
		end else begin
			// count until power good, then hold
			if (pon_end)
				pwr_ok <= 1'b1;
			else if (!pwr_ok)
				pon_cnt <= pon_cnt + 1'b1;
			// a new request restarts the pulse
			if (clear_src)
				clr_cnt <= CLR_LEN;
			else if (clr_cnt != '0)
				clr_cnt <= clr_cnt - 1'b1;
		end
	end

	// low while the pulse counter runs
	assign clm_ = (clr_cnt == '0);

endmodule

`default_nettype wire

// ==== hdl/panel_ctl.sv ====
`default_nettype none

module panel_ctl import mera_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       rx_valid,
	input  logic [7:0] rx_byte,
	output logic       tx_start,
	output logic [7:0] tx_byte,
	input  logic       tx_busy,
	input  logic       pwr_ok,
	input  logic       clm_,
	output logic       clr_req,
	output logic       op_req,
	output logic       op_write,
	output addr_t      op_addr,
	output word_t      op_wdata,
	input  word_t      op_rdata,
	input  logic       op_nomem,
	input  logic       op_ack
);

	typedef enum logic [2:0] {
		S_OP, S_HI, S_LO, S_CLR_LOW, S_CLR_HIGH, S_BUS, S_REL, S_SEND
	} state_t;

	state_t     state;
	addr_t      addr_q;
	logic [1:0] idx_q;
	logic [1:0] len_q;
	logic [7:0] op_q;
	word_t      data_q;
	word_t      rdata_q;
	logic [7:0] status_q;
	logic       rx_take;

	// bytes only count once power is up
	assign rx_take = rx_valid && pwr_ok;

	// ----------------------------------------------------------------------
	// frame decode and operation sequencing
	// ----------------------------------------------------------------------

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state  <= S_OP;
			addr_q <= '0;
			idx_q  <= '0;
			len_q  <= '0;
		end else begin
			case (state)
				S_OP:
					if (rx_take)
						state <= S_HI;
				S_HI:
					if (rx_take)
						state <= S_LO;
				S_LO:
					if (rx_take) begin
						// single status byte unless a fetch succeeds
						idx_q <= '0;
						len_q <= 2'd1;
						case (op_q)
							OP_LOAD: begin
								addr_q <= {data_q[0:7], rx_byte};
								state  <= S_SEND;
							end
							OP_STORE, OP_FETCH:
								state <= S_BUS;
							OP_CLEAR:
								state <= S_CLR_LOW;
							default:
								state <= S_SEND;
						endcase
					end
				// wait for the clear pulse to start
				S_CLR_LOW:
					if (!clm_)
						state <= S_CLR_HIGH;
				// and for it to end
				S_CLR_HIGH:
					if (clm_)
						state <= S_SEND;
				S_BUS:
					if (op_ack) begin
						if (!op_nomem) begin
							addr_q <= addr_q + addr_t'(1);
							if (op_q == OP_FETCH)
								len_q <= 2'd3;
						end
						state <= S_REL;
					end
				S_REL:
					if (!op_ack)
						state <= S_SEND;
				default:
					if (tx_start)
						idx_q <= idx_q + 1'b1;
					else if (!tx_busy && idx_q == len_q)
						state <= S_OP;
			endcase
			// clear from any source zeroes the address
			if (!clm_)
				addr_q <= '0;
		end
	end

	// frame and reply payload
	always_ff @(posedge clk) begin
		case (state)
			S_OP:
				if (rx_take)
					op_q <= rx_byte;
			S_HI:
				if (rx_take)
					data_q[0:7] <= rx_byte;
			S_LO:
				if (rx_take) begin
					data_q[8:15] <= rx_byte;
					status_q     <= (op_q == OP_LOAD) ? (ST_OK | op_q) : ST_NAK;
				end
			S_CLR_HIGH:
				status_q <= ST_OK | op_q;
			S_BUS:
				if (op_ack) begin
					rdata_q  <= op_rdata;
					status_q <= (op_nomem ? ST_NOMEM : ST_OK) | op_q;
				end
			default: ;
		endcase
	end

	// ----------------------------------------------------------------------
	// outputs
	// ----------------------------------------------------------------------

	assign clr_req  = (state == S_LO) && rx_take && (op_q == OP_CLEAR);
	assign op_req   = (state == S_BUS);
	assign op_write = (op_q == OP_STORE);
	assign op_addr  = addr_q;
	assign op_wdata = data_q;

	// next byte only when the transmitter is free
	assign tx_start = (state == S_SEND) && !tx_busy && (idx_q != len_q);

	// status, then data high, then data low
	always_comb begin
		case (idx_q)
			2'd0:    tx_byte = status_q;
			2'd1:    tx_byte = rdata_q[0:7];
			default: tx_byte = rdata_q[8:15];
		endcase
	end

	// four-phase rule toward the bus master
	a_req_held: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(op_req) |-> op_ack)
		else $error("op_req dropped before op_ack");

endmodule

`default_nettype wire

// ==== hdl/bus_master.sv ====
`default_nettype none

module bus_master import mera_pkg::*; #(
	parameter int NOMEM_TIMEOUT = 16
) (
	input  logic  clk,
	input  logic  arst_n,
	input  logic  clm_,
	input  logic  op_req,
	input  logic  op_write,
	input  addr_t op_addr,
	input  word_t op_wdata,
	output word_t op_rdata,
	output logic  op_nomem,
	output logic  op_ack,
	output logic  bus_req,
	output logic  bus_we,
	output addr_t bus_addr,
	output word_t bus_wdata,
	input  word_t bus_rdata,
	input  logic  bus_ack,
	output logic  alarm
);

	localparam int TW = $clog2(NOMEM_TIMEOUT + 1);
	// last cycle we wait for a memory answer
	localparam logic [TW-1:0] T_LAST = TW'(NOMEM_TIMEOUT - 1);

	typedef enum logic [1:0] {M_IDLE, M_REQ, M_REL, M_ACK} mstate_t;

	mstate_t       state;
	logic [TW-1:0] tcnt;
	word_t         rdata_q;

	// ----------------------------------------------------------------------
	// panel op to bus cycle
	// ----------------------------------------------------------------------

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= M_IDLE;
			tcnt     <= '0;
			op_nomem <= 1'b0;
			alarm    <= 1'b0;
		end else begin
			case (state)
				M_IDLE: begin
					tcnt <= '0;
					if (op_req)
						state <= M_REQ;
				end
				M_REQ: begin
					if (bus_ack) begin
						op_nomem <= 1'b0;
						state    <= M_REL;
					end else if (tcnt == T_LAST) begin
						// nobody answered, give up
						op_nomem <= 1'b1;
						alarm    <= 1'b1;
						state    <= M_ACK;
					end else
						tcnt <= tcnt + 1'b1;
				end
				// memory releases its ack
				M_REL:
					if (!bus_ack)
						state <= M_ACK;
				// panel releases its request
				default:
					if (!op_req)
						state <= M_IDLE;
			endcase
			// sticky until the next clear
			if (!clm_)
				alarm <= 1'b0;
		end
	end

	// read data captured with the ack
	always_ff @(posedge clk) begin
		if (state == M_REQ && bus_ack)
			rdata_q <= bus_rdata;
	end

	assign op_rdata  = rdata_q;
	assign op_ack    = (state == M_ACK);
	assign bus_req   = (state == M_REQ);
	// panel holds these steady during op_req
	assign bus_we    = op_write;
	assign bus_addr  = op_addr;
	assign bus_wdata = op_wdata;

	// panel must keep the address for the whole bus cycle
	a_addr_stable: assert property (@(posedge clk) disable iff (!arst_n)
		bus_req |=> !bus_req || $stable(bus_addr))
		else $error("bus_addr changed during bus_req");

endmodule

`default_nettype wire

// ==== hdl/bus_memory.sv ====
`default_nettype none

module bus_memory import mera_pkg::*; #(
	parameter int MEM_WORDS = 64
) (
	input  logic  clk,
	input  logic  arst_n,
	input  logic  bus_req,
	input  logic  bus_we,
	input  addr_t bus_addr,
	input  word_t bus_wdata,
	output word_t bus_rdata,
	output logic  bus_ack
);

	localparam int AW = $clog2(MEM_WORDS);
	// first address not backed by the array
	localparam addr_t ADDR_LIMIT = addr_t'(MEM_WORDS);

	word_t         mem [0:MEM_WORDS-1];
	logic [AW-1:0] mem_idx;
	logic          hit;

	// low address bits select the word
	assign mem_idx = AW'(bus_addr);

	// new in-range request not yet answered
	assign hit = bus_req && !bus_ack && (bus_addr < ADDR_LIMIT);

	// ----------------------------------------------------------------------
	// handshake
	// ----------------------------------------------------------------------

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			bus_ack <= 1'b0;
		else if (hit)
			bus_ack <= 1'b1;
		// release follows the master
		else if (!bus_req)
			bus_ack <= 1'b0;
	end

	// ----------------------------------------------------------------------
	// storage
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (hit) begin
			if (bus_we)
				mem[mem_idx] <= bus_wdata;
			else
				bus_rdata <= mem[mem_idx];
		end
	end

endmodule

`default_nettype wire

// ==== hdl/mera_top.sv ====
`default_nettype none

module mera_top import mera_pkg::*; #(
	parameter int CLKS_PER_BIT  = 8,
	parameter int MEM_WORDS     = 64,
	parameter int NOMEM_TIMEOUT = 16,
	parameter int PON_CYCLES    = 40,
	parameter int CLEAR_CYCLES  = 4
) (
	input  logic clk_ext,
	input  logic arst_n,
	input  logic rxd,
	output logic txd,
	output logic alarm
);

	// serial link to panel
	logic       rx_valid;
	logic [7:0] rx_byte;
	logic       tx_start;
	logic [7:0] tx_byte;
	logic       tx_busy;
	// power and clear
	logic       pwr_ok;
	logic       clm_;
	logic       clr_req;
	// panel to bus master
	logic       op_req;
	logic       op_write;
	addr_t      op_addr;
	word_t      op_wdata;
	word_t      op_rdata;
	logic       op_nomem;
	logic       op_ack;
	// system bus
	logic       bus_req;
	logic       bus_we;
	addr_t      bus_addr;
	word_t      bus_wdata;
	word_t      bus_rdata;
	logic       bus_ack;

	// ----------------------------------------------------------------------
	// control panel
	// ----------------------------------------------------------------------

	uart_link #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart (
		.clk(clk_ext), .arst_n(arst_n), .rxd(rxd), .txd(txd),
		.rx_valid(rx_valid), .rx_byte(rx_byte),
		.tx_start(tx_start), .tx_byte(tx_byte), .tx_busy(tx_busy)
	);

	panel_ctl panel (
		.clk(clk_ext), .arst_n(arst_n),
		.rx_valid(rx_valid), .rx_byte(rx_byte),
		.tx_start(tx_start), .tx_byte(tx_byte), .tx_busy(tx_busy),
		.pwr_ok(pwr_ok), .clm_(clm_), .clr_req(clr_req),
		.op_req(op_req), .op_write(op_write), .op_addr(op_addr),
		.op_wdata(op_wdata), .op_rdata(op_rdata),
		.op_nomem(op_nomem), .op_ack(op_ack)
	);

	// ----------------------------------------------------------------------
	// power supply
	// ----------------------------------------------------------------------

	power_seq #(.PON_CYCLES(PON_CYCLES), .CLEAR_CYCLES(CLEAR_CYCLES)) pseq (
		.clk(clk_ext), .arst_n(arst_n), .clr_req(clr_req),
		.pwr_ok(pwr_ok), .clm_(clm_)
	);

	// ----------------------------------------------------------------------
	// system bus and memory
	// ----------------------------------------------------------------------

	bus_master #(.NOMEM_TIMEOUT(NOMEM_TIMEOUT)) master (
		.clk(clk_ext), .arst_n(arst_n), .clm_(clm_),
		.op_req(op_req), .op_write(op_write), .op_addr(op_addr),
		.op_wdata(op_wdata), .op_rdata(op_rdata),
		.op_nomem(op_nomem), .op_ack(op_ack),
		.bus_req(bus_req), .bus_we(bus_we), .bus_addr(bus_addr),
		.bus_wdata(bus_wdata), .bus_rdata(bus_rdata), .bus_ack(bus_ack),
		.alarm(alarm)
	);

	bus_memory #(.MEM_WORDS(MEM_WORDS)) mem (
		.clk(clk_ext), .arst_n(arst_n),
		.bus_req(bus_req), .bus_we(bus_we), .bus_addr(bus_addr),
		.bus_wdata(bus_wdata), .bus_rdata(bus_rdata), .bus_ack(bus_ack)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_mera_top.sv ====
`default_nettype none

module tb_mera_top import mera_pkg::*;;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLKS_PER_BIT  = 8;
	localparam int MEM_WORDS     = 64;
	localparam int NOMEM_TIMEOUT = 16;
	localparam int PON_CYCLES    = 40;
	localparam int CLEAR_CYCLES  = 4;
	localparam int CLK_PERIOD    = 100;
	// fill, 20 pairs of five frames, and the short tests
	localparam int N_FRAMES      = 180;
	// four bytes of ten bits per frame, half as much again for margin
	localparam int WATCHDOG_NS   = (N_FRAMES * 4 * 10 * CLKS_PER_BIT * CLK_PERIOD * 3) / 2;
	// three frame bytes plus decode slack
	localparam int REPLY_WAIT    = 3 * 10 * CLKS_PER_BIT + 200;
	// gap allowed between reply bytes
	localparam int BYTE_GAP      = 3 * CLKS_PER_BIT;

	logic  clk_ext = 1'b0;
	logic  arst_n;
	logic  rxd;
	logic  txd;
	logic  alarm;

	// reference model
	word_t       m_mem [0:MEM_WORDS-1];
	addr_t       m_addr;
	logic        m_alarm;
	logic [15:0] lfsr;

	int checks;
	int errors;
	int tests_run;

	mera_top #(
		.CLKS_PER_BIT(CLKS_PER_BIT), .MEM_WORDS(MEM_WORDS),
		.NOMEM_TIMEOUT(NOMEM_TIMEOUT), .PON_CYCLES(PON_CYCLES),
		.CLEAR_CYCLES(CLEAR_CYCLES)
	) UUT (
		.clk_ext(clk_ext), .arst_n(arst_n), .rxd(rxd), .txd(txd), .alarm(alarm)
	);

	always #(CLK_PERIOD / 2) clk_ext = ~clk_ext;

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
		$display("TESTS FAILED");
		$finish;
	end

	// ----------------------------------------------------------------------
	// random source
	// ----------------------------------------------------------------------

	// 16-bit fibonacci, taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// one step per bit taken
	task automatic take_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v    = {v[14:0], lfsr[0]};
		end
	endtask

	// ----------------------------------------------------------------------
	// compare tasks
	// ----------------------------------------------------------------------

	task automatic check_status(input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL status: got 0x%02h, expected 0x%02h", got, exp);
		end
	endtask

	task automatic check_word(input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL fetch word: got 0x%04h, expected 0x%04h", got, exp);
		end
	endtask

	task automatic check_alarm(input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL alarm: got 0x%0h, expected 0x%0h", got, exp);
		end
	endtask

	// ----------------------------------------------------------------------
	// serial host
	// ----------------------------------------------------------------------

	// 8N1, lsb first, changes on the falling edge
	task automatic send_byte(input logic [7:0] b);
		@(negedge clk_ext);
		rxd = 1'b0;
		repeat (CLKS_PER_BIT) @(negedge clk_ext);
		for (int i = 0; i < 8; i++) begin
			rxd = b[i];
			repeat (CLKS_PER_BIT) @(negedge clk_ext);
		end
		rxd = 1'b1;
		repeat (CLKS_PER_BIT) @(negedge clk_ext);
	endtask

	task automatic send_frame(input logic [7:0] op, input word_t data);
		send_byte(op);
		send_byte(data[0:7]);
		send_byte(data[8:15]);
	endtask

	// got stays low if no start bit shows up in time
	task automatic get_byte(input int wait_cycles, output logic got, output logic [7:0] b);
		int n;
		got = 1'b0;
		b   = '0;
		n   = 0;
		while (txd !== 1'b0 && n < wait_cycles) begin
			@(negedge clk_ext);
			n++;
		end
		if (txd === 1'b0) begin
			// start seen within half a clock, move to mid-bit
			repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk_ext);
			if (txd !== 1'b0) begin
				errors++;
				$display("start bit on txd lasted less than half a bit");
			end
			for (int i = 0; i < 8; i++) begin
				repeat (CLKS_PER_BIT) @(negedge clk_ext);
				b[i] = txd;
			end
			repeat (CLKS_PER_BIT) @(negedge clk_ext);
			if (txd !== 1'b1) begin
				errors++;
				$display("stop bit on txd was not high");
			end
			got = 1'b1;
		end
	endtask

	// ----------------------------------------------------------------------
	// one command against the model
	// ----------------------------------------------------------------------

	task automatic run_frame(input logic [7:0] op, input word_t data);
		logic [7:0] exp_st;
		logic       exp_data;
		word_t      exp_word;
		logic       got;
		logic [7:0] st;
		logic [7:0] hi;
		logic [7:0] lo;
		exp_data = 1'b0;
		exp_word = '0;
		case (op)
			OP_LOAD: begin
				m_addr = data;
				exp_st = 8'h80 + op;
			end
			OP_STORE, OP_FETCH: begin
				if (int'(m_addr) < MEM_WORDS) begin
					exp_st = 8'h80 + op;
					if (op == OP_STORE)
						m_mem[int'(m_addr)] = data;
					else begin
						exp_data = 1'b1;
						exp_word = m_mem[int'(m_addr)];
					end
					m_addr = m_addr + addr_t'(1);
				end else begin
					// nobody answers, sticky alarm
					exp_st  = 8'h40 + op;
					m_alarm = 1'b1;
				end
			end
			OP_CLEAR: begin
				exp_st  = 8'h80 + op;
				m_addr  = '0;
				m_alarm = 1'b0;
			end
			default:
				exp_st = 8'h15;
		endcase
		// reply may start before the last stop bit ends
		fork
			send_frame(op, data);
			get_byte(REPLY_WAIT, got, st);
		join
		if (!got) begin
			errors++;
			$display("no reply to opcode 0x%02h within %0d cycles", op, REPLY_WAIT);
		end else begin
			check_status(st, exp_st);
			if (exp_data) begin
				get_byte(BYTE_GAP, got, hi);
				if (got)
					get_byte(BYTE_GAP, got, lo);
				if (!got) begin
					errors++;
					$display("fetch reply ended before both data bytes");
				end else
					check_word({hi, lo}, exp_word);
			end else begin
				get_byte(BYTE_GAP, got, hi);
				if (got) begin
					errors++;
					$display("extra byte 0x%02h after status 0x%02h", hi, st);
				end
			end
		end
		check_alarm(alarm, m_alarm);
	endtask

	task automatic end_test(input string name, input int err_before);
		tests_run++;
		if (errors == err_before)
			$display("test %0d %s: ok", tests_run, name);
		else
			$display("test %0d %s: %0d errors", tests_run, name, errors - err_before);
	endtask

	// ----------------------------------------------------------------------
	// test sequence
	// ----------------------------------------------------------------------

	initial begin
		logic [15:0] v;
		addr_t       a;
		word_t       d;
		logic [7:0]  op;
		logic        exp_ok;
		int          err_before;
		arst_n    = 1'b0;
		rxd       = 1'b1;
		lfsr      = 16'd62;
		m_addr    = '0;
		m_alarm   = 1'b0;
		checks    = 0;
		errors    = 0;
		tests_run = 0;
		repeat (2) @(negedge clk_ext);
		arst_n = 1'b1;

		// a byte needs about 78 clocks here, longer than the hold,
		// so the hold is watched on pwr_ok and an idle txd
		err_before = errors;
		for (int k = 1; k <= PON_CYCLES; k++) begin
			@(negedge clk_ext);
			exp_ok = (k >= PON_CYCLES);
			checks++;
			if (UUT.pwr_ok !== exp_ok) begin
				errors++;
				$display("FAIL pwr_ok at cycle %0d: got 0x%0h, expected 0x%0h",
					k, UUT.pwr_ok, exp_ok);
			end
			if (txd !== 1'b1) begin
				errors++;
				$display("txd left idle during the power-on hold");
			end
		end
		take_bits(6, v);
		run_frame(OP_LOAD, v);
		end_test("power-on hold and load", err_before);

		// fill every word, then random pairs
		err_before = errors;
		run_frame(OP_LOAD, '0);
		for (int i = 0; i < MEM_WORDS; i++) begin
			take_bits(16, v);
			run_frame(OP_STORE, v);
		end
		for (int i = 0; i < 20; i++) begin
			take_bits(6, v);
			// keep the next word in range
			a = addr_t'(int'(v) % (MEM_WORDS - 1));
			take_bits(16, v);
			d = v;
			run_frame(OP_LOAD, a);
			run_frame(OP_STORE, d);
			run_frame(OP_FETCH, '0);
			run_frame(OP_LOAD, a);
			run_frame(OP_FETCH, '0);
		end
		end_test("random store and fetch", err_before);

		// unknown opcode must not move the address
		err_before = errors;
		take_bits(6, v);
		run_frame(OP_LOAD, v);
		take_bits(8, v);
		op = v[7:0];
		if (op >= 8'd1 && op <= 8'd4)
			op = op | 8'h80;
		take_bits(16, v);
		run_frame(op, v);
		run_frame(OP_FETCH, '0);
		end_test("unknown opcode", err_before);

		// fetch above the memory
		err_before = errors;
		take_bits(16, v);
		if (int'(v) < MEM_WORDS)
			v = v + 16'(MEM_WORDS);
		run_frame(OP_LOAD, v);
		run_frame(OP_FETCH, '0);
		end_test("missing memory", err_before);

		// clear drops alarm and zeroes the address
		err_before = errors;
		run_frame(OP_CLEAR, '0);
		run_frame(OP_FETCH, '0);
		end_test("clear", err_before);

		$display("%0d tests run, %0d checks, %0d errors", tests_run, checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
hdl/mera_pkg.sv
hdl/uart_link.sv
hdl/power_seq.sv
hdl/panel_ctl.sv
hdl/bus_master.sv
hdl/bus_memory.sv
hdl/mera_top.sv
testbench/tb_mera_top.sv

// ==== Makefile ====
TOP = tb_mera_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f vlog.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f vlog.f \
		--Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
